/* Makefile */
VERILATOR	?= verilator
TOP			?= tb_vec_lane_array
RTL_TOP		?= vec_lane_array
FILELIST	?= filelist.f
BUILD_DIR	?= obj_dir
LOG			?= sim.log
PASS_MSG	?= All tests passed!
VFLAGS		?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* filelist.f */
+incdir+.
vec_pkg.sv
lane_cmd_if.sv
issue_ctrl.sv
lane_bypass_buff.sv
lane_path_sel.sv
vec_lane.sv
wb_collector.sv
vec_lane_array.sv
tb_vec_lane_array.sv

/* issue_ctrl.sv */
/*
 * Command issuer
 * Registers one accepted command per cycle and broadcasts it to the lanes
 */

`timescale 1ns/1ps

module issue_ctrl (
	input							clock,
	input							rst,
	input							stall,			// Global pipeline hold
	input							req,			// Command request
	input	vec_pkg::op_e			op,
	input	vec_pkg::index_t		dst_idx,
	input	vec_pkg::index_t		src1_idx,
	input	vec_pkg::index_t		src2_idx,
	input	vec_pkg::path_e			src1_path,
	input	vec_pkg::path_e			src2_path,
	input	vec_pkg::data_t			scalar_data,	// From scalar side
	lane_cmd_if.issue				cmd
);

	logic							accept;

	assign accept		= req & ~stall;

	////////////////////
	// Stage A valid

	// A free cycle with no request issues a bubble
	always_ff @(posedge clock) begin
		if (rst) begin
			cmd.valid	<= 1'b0;
		end else if (!stall) begin
			cmd.valid	<= req;
		end
	end

	////////////////////
	// Stage A payload

	always_ff @(posedge clock) begin
		if (accept) begin
			cmd.op			<= op;
			cmd.dst			<= dst_idx;
			cmd.src1_idx	<= src1_idx;
			cmd.src2_idx	<= src2_idx;
			cmd.src1_path	<= src1_path;
			cmd.src2_path	<= src2_path;
			cmd.scalar		<= scalar_data;
		end
	end

endmodule

/* lane_bypass_buff.sv */
/*
 * Lane bypass buffer
 * Forwards in-flight write-backs to reads, retires the oldest to the RF
 */

`timescale 1ns/1ps

`include "vec_cfg.svh"

module lane_bypass_buff (
	input							clock,
	input							rst,
	input							stall,
	input							wr_valid,		// New write-back
	input	vec_pkg::index_t		wr_idx,
	input	vec_pkg::data_t			wr_data,
	input	vec_pkg::index_t		rd_idx1,
	input	vec_pkg::index_t		rd_idx2,
	input	vec_pkg::data_t			rf_data1,		// Raw RF read
	input	vec_pkg::data_t			rf_data2,
	output	vec_pkg::data_t			rd_data1,		// Corrected read
	output	vec_pkg::data_t			rd_data2,
	output							retire_valid,	// Oldest entry leaving
	output	vec_pkg::index_t		retire_idx,
	output	vec_pkg::data_t			retire_data
);

	localparam int DEPTH = `VEC_BYPASS_DEPTH;

	logic	[DEPTH-1:0]				ent_valid;		// Entry 0 is newest
	vec_pkg::index_t				ent_idx [DEPTH];
	vec_pkg::data_t					ent_data [DEPTH];

	////////////////////
	// Shift register

	always_ff @(posedge clock) begin
		if (rst) begin
			ent_valid	<= '0;
		end else if (!stall) begin
			ent_valid	<= {ent_valid[DEPTH-2:0], wr_valid};
		end
	end

	always_ff @(posedge clock) begin
		if (!stall) begin
			ent_idx[0]		<= wr_idx;
			ent_data[0]		<= wr_data;
			for (int i = 1; i < DEPTH; i++) begin
				ent_idx[i]	<= ent_idx[i-1];
				ent_data[i]	<= ent_data[i-1];
			end
		end
	end

	////////////////////
	// Lookup

	// Walk oldest to newest so the newest match wins
	always_comb begin
		rd_data1 = rf_data1;
		rd_data2 = rf_data2;
		for (int i = DEPTH - 1; i >= 0; i--) begin
			if (ent_valid[i] && (ent_idx[i] == rd_idx1)) rd_data1 = ent_data[i];
			if (ent_valid[i] && (ent_idx[i] == rd_idx2)) rd_data2 = ent_data[i];
		end
	end

	assign retire_valid	= ent_valid[DEPTH-1];
	assign retire_idx	= ent_idx[DEPTH-1];
	assign retire_data	= ent_data[DEPTH-1];

endmodule

/* lane_cmd_if.sv */
/*
 * Lane command bus
 * Carries the issued vector command from the issuer to every lane
 */

`timescale 1ns/1ps

interface lane_cmd_if;

	logic					valid;		// Command in stage A
	vec_pkg::op_e			op;
	vec_pkg::index_t		dst;		// Write-back register
	vec_pkg::index_t		src1_idx;
	vec_pkg::index_t		src2_idx;
	vec_pkg::path_e			src1_path;
	vec_pkg::path_e			src2_path;
	vec_pkg::data_t			scalar;		// Broadcast operand

	modport issue (
		output	valid, op, dst, src1_idx, src2_idx,
		output	src1_path, src2_path, scalar
	);

	modport lane (
		input	valid, op, dst, src1_idx, src2_idx,
		input	src1_path, src2_path, scalar
	);

endinterface

/* lane_path_sel.sv */
/*
 * Operand path selector
 * Picks each ALU operand from the own lane, a neighbour or the scalar
 */

`timescale 1ns/1ps

module lane_path_sel (
	input	vec_pkg::path_e			path1,
	input	vec_pkg::path_e			path2,
	input	vec_pkg::data_t			own1,		// This lane
	input	vec_pkg::data_t			own2,
	input	vec_pkg::data_t			left1,		// Lane i-1
	input	vec_pkg::data_t			left2,
	input	vec_pkg::data_t			right1,		// Lane i+1
	input	vec_pkg::data_t			right2,
	input	vec_pkg::data_t			scalar,
	output	vec_pkg::data_t			src1,
	output	vec_pkg::data_t			src2
);

	function automatic vec_pkg::data_t pick (
		input vec_pkg::path_e	path,
		input vec_pkg::data_t	own,
		input vec_pkg::data_t	left,
		input vec_pkg::data_t	right,
		input vec_pkg::data_t	scl
	);
		case (path)
			vec_pkg::PATH_LEFT:		return left;
			vec_pkg::PATH_RIGHT:	return right;
			vec_pkg::PATH_SCALAR:	return scl;
			default:				return own;
		endcase
	endfunction

	// First operand takes the first read of the chosen source
	assign src1		= pick(path1, own1, left1, right1, scalar);
	assign src2		= pick(path2, own2, left2, right2, scalar);

endmodule

/* tb_vec_lane_array.sv */
/*
 * Vector lane array testbench
 * Directed tests against a per-lane register file model
 */

`timescale 1ns/1ps

`include "vec_cfg.svh"

module tb_vec_lane_array;

	localparam int LANES	= `VEC_NUM_LANES;
	localparam int W		= `VEC_DATA_W;

	logic							clock;
	logic							rst;
	logic							stall;
	logic							req;
	vec_pkg::op_e					op;
	vec_pkg::index_t				dst_idx;
	vec_pkg::index_t				src1_idx;
	vec_pkg::index_t				src2_idx;
	vec_pkg::path_e					src1_path;
	vec_pkg::path_e					src2_path;
	vec_pkg::data_t					scalar_data;
	logic							result_valid;
	vec_pkg::index_t				result_dst;
	logic [LANES*W-1:0]				result_data;

	vec_pkg::data_t					model_rf [LANES][`VEC_NUM_REGS];	// Reference registers
	logic [LANES*W-1:0]				exp_data [$];
	vec_pkg::index_t				exp_dst [$];
	int								exp_edge [$];	// Edge count when result shows
	int								adv_edges;		// Non-stalled edges since reset
	int								seen_edges;
	int								error_count;
	logic							held_valid;
	logic [LANES*W-1:0]				held_data;
	vec_pkg::data_t					got_word;
	vec_pkg::data_t					exp_word;

	vec_lane_array u_dut (
		.clock			(clock),
		.rst			(rst),
		.stall			(stall),
		.req			(req),
		.op				(op),
		.dst_idx		(dst_idx),
		.src1_idx		(src1_idx),
		.src2_idx		(src2_idx),
		.src1_path		(src1_path),
		.src2_path		(src2_path),
		.scalar_data	(scalar_data),
		.result_valid	(result_valid),
		.result_dst		(result_dst),
		.result_data	(result_data)
	);

	always #4 clock = ~clock;

	always @(posedge clock) begin
		if (!rst && !stall) adv_edges <= adv_edges + 1;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failures found");
		error_count++;
		$fatal(1, "Stopped at first error");
	endtask

	////////////////////
	// Reference model

	function automatic vec_pkg::data_t pick_operand(input vec_pkg::path_e path, input int lane,
			input vec_pkg::index_t idx, input vec_pkg::data_t scl);
		case (path)
			vec_pkg::PATH_LEFT:		return model_rf[(lane + LANES - 1) % LANES][idx];
			vec_pkg::PATH_RIGHT:	return model_rf[(lane + 1) % LANES][idx];
			vec_pkg::PATH_SCALAR:	return scl;
			default:				return model_rf[lane][idx];
		endcase
	endfunction

	function automatic vec_pkg::data_t alu_ref(input vec_pkg::op_e c_op, input vec_pkg::data_t a,
			input vec_pkg::data_t b, input vec_pkg::data_t scl, input int lane);
		case (c_op)
			vec_pkg::OP_ADD:	return a + b;
			vec_pkg::OP_SUB:	return a - b;
			vec_pkg::OP_AND:	return a & b;
			vec_pkg::OP_XOR:	return a ^ b;
			vec_pkg::OP_BCAST:	return scl;
			default:			return vec_pkg::data_t'(lane);	// Lane number
		endcase
	endfunction

	function automatic vec_pkg::index_t rand_src();
		return vec_pkg::index_t'($urandom_range(7, 0));
	endfunction

	function automatic vec_pkg::index_t rand_dst();
		return vec_pkg::index_t'($urandom_range(7, 1));		// R0 stays zero
	endfunction

	////////////////////
	// Drivers

	task automatic issue_cmd(input vec_pkg::op_e c_op, input vec_pkg::index_t c_dst,
			input vec_pkg::index_t c_s1, input vec_pkg::index_t c_s2,
			input vec_pkg::path_e c_p1, input vec_pkg::path_e c_p2, input vec_pkg::data_t c_scl);
		vec_pkg::data_t		a;
		vec_pkg::data_t		b;
		logic [LANES*W-1:0]	vec;
		for (int l = 0; l < LANES; l++) begin
			a = pick_operand(c_p1, l, c_s1, c_scl);
			b = pick_operand(c_p2, l, c_s2, c_scl);
			vec[l*W +: W] = alu_ref(c_op, a, b, c_scl, l);
		end
		for (int l = 0; l < LANES; l++) model_rf[l][c_dst] = vec[l*W +: W];
		exp_data.push_back(vec);
		exp_dst.push_back(c_dst);
		exp_edge.push_back(adv_edges + 3);		// Accept edge plus two stages
		op			= c_op;
		dst_idx		= c_dst;
		src1_idx	= c_s1;
		src2_idx	= c_s2;
		src1_path	= c_p1;
		src2_path	= c_p2;
		scalar_data	= c_scl;
		req			= 1'b1;
		@(posedge clock);
		#1;
		req			= 1'b0;
	endtask

	task automatic wait_drain();
		int cycles;
		cycles = 0;
		while (exp_data.size() != 0) begin
			@(posedge clock);
			cycles++;
			if (cycles > 60)
				abort_run($sformatf("Timeout waiting for results, %0d still outstanding",
					exp_data.size()));
		end
		#1;
	endtask

	////////////////////
	// Result checker

	task automatic check_result();
		assert (exp_data.size() != 0)
			else abort_run($sformatf("Unexpected result at %0t with nothing issued", $time));
		for (int l = 0; l < LANES; l++) begin
			got_word = result_data[l*W +: W];
			exp_word = exp_data[0][l*W +: W];
			assert (got_word === exp_word) else abort_run($sformatf(
				"CHECK FAILED at %0t: result_data lane %0d got %h expected %h",
				$time, l, got_word, exp_word));
		end
		assert (result_dst === exp_dst[0]) else abort_run($sformatf(
			"CHECK FAILED at %0t: result_dst got %0d expected %0d",
			$time, result_dst, exp_dst[0]));
		assert (adv_edges == exp_edge[0]) else abort_run($sformatf(
			"CHECK FAILED at %0t: result_valid edge got %0d expected %0d",
			$time, adv_edges, exp_edge[0]));
		void'(exp_data.pop_front());
		void'(exp_dst.pop_front());
		void'(exp_edge.pop_front());
	endtask

	// A result is new only after an edge that advanced the pipeline
	always @(negedge clock) begin
		if (!rst && (adv_edges != seen_edges)) begin
			seen_edges = adv_edges;
			if (result_valid) check_result();
		end else if (!rst) begin
			assert (result_valid === held_valid) else abort_run($sformatf(
				"CHECK FAILED at %0t: result_valid got %b expected %b",
				$time, result_valid, held_valid));
			if (held_valid) begin
				assert (result_data === held_data) else abort_run($sformatf(
					"CHECK FAILED at %0t: result_data got %h expected %h",
					$time, result_data, held_data));
			end
		end
		held_valid	= result_valid;
		held_data	= result_data;
	end

	////////////////////
	// Tests

	task automatic test_bcast_laneid();
		issue_cmd(vec_pkg::OP_BCAST, 3'd1, 3'd0, 3'd0, vec_pkg::PATH_OWN, vec_pkg::PATH_OWN,
			$urandom);
		issue_cmd(vec_pkg::OP_LANEID, 3'd2, 3'd0, 3'd0, vec_pkg::PATH_OWN, vec_pkg::PATH_OWN,
			$urandom);
		wait_drain();
		issue_cmd(vec_pkg::OP_XOR, 3'd3, 3'd1, 3'd0, vec_pkg::PATH_OWN, vec_pkg::PATH_OWN, '0);
		issue_cmd(vec_pkg::OP_XOR, 3'd4, 3'd2, 3'd0, vec_pkg::PATH_OWN, vec_pkg::PATH_OWN, '0);
		wait_drain();
	endtask

	task automatic test_alu_own();
		issue_cmd(vec_pkg::OP_LANEID, 3'd7, 3'd0, 3'd0, vec_pkg::PATH_OWN, vec_pkg::PATH_OWN, '0);
		issue_cmd(vec_pkg::OP_ADD, 3'd6, 3'd7, 3'd0, vec_pkg::PATH_OWN, vec_pkg::PATH_SCALAR,
			$urandom);		// Lane dependent contents
		issue_cmd(vec_pkg::OP_BCAST, 3'd5, 3'd0, 3'd0, vec_pkg::PATH_OWN, vec_pkg::PATH_OWN,
			$urandom);
		for (int k = 0; k < 12; k++) begin
			issue_cmd(vec_pkg::op_e'(k % 4), rand_dst(), rand_src(), rand_src(),
				vec_pkg::PATH_OWN, vec_pkg::PATH_OWN, $urandom);
		end
		wait_drain();
	endtask

	task automatic test_neighbour();
		issue_cmd(vec_pkg::OP_LANEID, 3'd7, 3'd0, 3'd0, vec_pkg::PATH_OWN, vec_pkg::PATH_OWN, '0);
		issue_cmd(vec_pkg::OP_ADD, 3'd6, 3'd7, 3'd0, vec_pkg::PATH_OWN, vec_pkg::PATH_SCALAR,
			$urandom);
		wait_drain();
		issue_cmd(vec_pkg::OP_ADD, 3'd3, 3'd7, 3'd6, vec_pkg::PATH_LEFT, vec_pkg::PATH_RIGHT, '0);
		issue_cmd(vec_pkg::OP_SUB, 3'd4, 3'd6, 3'd7, vec_pkg::PATH_LEFT, vec_pkg::PATH_RIGHT, '0);
		issue_cmd(vec_pkg::OP_XOR, 3'd5, 3'd7, 3'd0, vec_pkg::PATH_RIGHT, vec_pkg::PATH_SCALAR,
			$urandom);
		for (int k = 0; k < 8; k++) begin
			issue_cmd(vec_pkg::op_e'($urandom_range(3, 0)), rand_dst(), rand_src(), rand_src(),
				vec_pkg::path_e'($urandom_range(3, 0)), vec_pkg::path_e'($urandom_range(3, 0)),
				$urandom);
		end
		wait_drain();
	endtask

	task automatic test_back_to_back();
		issue_cmd(vec_pkg::OP_ADD, 3'd1, 3'd7, 3'd0, vec_pkg::PATH_OWN, vec_pkg::PATH_SCALAR,
			$urandom);
		issue_cmd(vec_pkg::OP_XOR, 3'd2, 3'd1, 3'd7, vec_pkg::PATH_OWN, vec_pkg::PATH_OWN, '0);
		issue_cmd(vec_pkg::OP_ADD, 3'd3, 3'd1, 3'd2, vec_pkg::PATH_OWN, vec_pkg::PATH_OWN, '0);
		issue_cmd(vec_pkg::OP_SUB, 3'd4, 3'd1, 3'd3, vec_pkg::PATH_OWN, vec_pkg::PATH_OWN, '0);
		// Same register twice in flight, newest must win
		issue_cmd(vec_pkg::OP_BCAST, 3'd5, 3'd0, 3'd0, vec_pkg::PATH_OWN, vec_pkg::PATH_OWN,
			$urandom);
		issue_cmd(vec_pkg::OP_BCAST, 3'd5, 3'd0, 3'd0, vec_pkg::PATH_OWN, vec_pkg::PATH_OWN,
			$urandom);
		issue_cmd(vec_pkg::OP_ADD, 3'd6, 3'd5, 3'd0, vec_pkg::PATH_OWN, vec_pkg::PATH_OWN, '0);
		for (int k = 0; k < 10; k++) begin
			issue_cmd(vec_pkg::op_e'($urandom_range(3, 0)), vec_pkg::index_t'(k % 7 + 1),
				vec_pkg::index_t'((k + 6) % 7 + 1), vec_pkg::index_t'((k + 5) % 7 + 1),
				vec_pkg::PATH_OWN, vec_pkg::path_e'($urandom_range(3, 0)), $urandom);
		end
		wait_drain();
	endtask

	task automatic test_stall();
		int n;
		for (int round = 0; round < 2; round++) begin
			issue_cmd(vec_pkg::OP_BCAST, 3'd3, 3'd0, 3'd0, vec_pkg::PATH_OWN, vec_pkg::PATH_OWN,
				$urandom);
			issue_cmd(vec_pkg::OP_ADD, 3'd4, 3'd3, 3'd7, vec_pkg::PATH_OWN, vec_pkg::PATH_OWN, '0);
			issue_cmd(vec_pkg::OP_XOR, 3'd5, 3'd4, 3'd3, vec_pkg::PATH_LEFT, vec_pkg::PATH_OWN, '0);
			n = $urandom_range(6, 2);
			stall		= 1'b1;
			req			= 1'b1;		// Must be ignored
			op			= vec_pkg::OP_BCAST;
			dst_idx		= 3'd1;
			scalar_data	= $urandom;
			repeat (n) @(posedge clock);
			#1;
			stall		= 1'b0;
			req			= 1'b0;
			issue_cmd(vec_pkg::OP_SUB, 3'd6, 3'd5, 3'd4, vec_pkg::PATH_OWN, vec_pkg::PATH_OWN, '0);
			issue_cmd(vec_pkg::OP_XOR, 3'd2, 3'd1, 3'd0, vec_pkg::PATH_OWN, vec_pkg::PATH_OWN, '0);
			wait_drain();
		end
	endtask

	initial begin
		void'($urandom(32'hd3f6));
		clock		= 1'b0;
		rst			= 1'b1;
		stall		= 1'b0;
		req			= 1'b0;
		op			= vec_pkg::OP_ADD;
		dst_idx		= '0;
		src1_idx	= '0;
		src2_idx	= '0;
		src1_path	= vec_pkg::PATH_OWN;
		src2_path	= vec_pkg::PATH_OWN;
		scalar_data	= '0;
		adv_edges	= 0;
		seen_edges	= 0;
		error_count	= 0;
		held_valid	= 1'b0;
		held_data	= '0;
		for (int l = 0; l < LANES; l++) begin
			for (int r = 0; r < `VEC_NUM_REGS; r++) model_rf[l][r] = '0;
		end
		repeat (4) @(posedge clock);
		#1;
		rst			= 1'b0;
		test_bcast_laneid();
		test_alu_own();
		test_neighbour();
		test_back_to_back();
		test_stall();
		if (error_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

/* vec_cfg.svh */
/*
 * Vector lane array configuration
 * Lane count, word width, register file and bypass depth
 */

`ifndef VEC_CFG_SVH
`define VEC_CFG_SVH

// Number of SIMD lanes
`define VEC_NUM_LANES		4

// Width of one lane word
`define VEC_DATA_W			32

// Registers per lane
`define VEC_NUM_REGS		8

// In-flight write-back entries per lane
`define VEC_BYPASS_DEPTH	2

`endif

/* vec_lane.sv */
/*
 * Vector lane
 * Register file, bypass buffer, path selector, ALU and stage B result register
 */

`timescale 1ns/1ps

`include "vec_cfg.svh"

module vec_lane #(
	parameter int LANE_ID = 0
)(
	input							clock,
	input							rst,
	input							stall,
	lane_cmd_if.lane				cmd,
	input	vec_pkg::data_t			left1,			// Operands of lane i-1
	input	vec_pkg::data_t			left2,
	input	vec_pkg::data_t			right1,			// Operands of lane i+1
	input	vec_pkg::data_t			right2,
	output	vec_pkg::data_t			opnd1,			// Bypassed reads
	output	vec_pkg::data_t			opnd2,
	output	logic					res_valid,		// Stage B
	output	vec_pkg::index_t		res_dst,
	output	vec_pkg::data_t			res_data
);

	localparam vec_pkg::lane_id_t LANE_NUM = vec_pkg::lane_id_t'(LANE_ID);

	vec_pkg::data_t					rf [`VEC_NUM_REGS];
	vec_pkg::data_t					rf_data1;
	vec_pkg::data_t					rf_data2;
	vec_pkg::data_t					alu_a;
	vec_pkg::data_t					alu_b;
	vec_pkg::data_t					alu_res;
	logic							retire_valid;
	vec_pkg::index_t				retire_idx;
	vec_pkg::data_t					retire_data;

	////////////////////
	// Register file

	assign rf_data1		= rf[cmd.src1_idx];
	assign rf_data2		= rf[cmd.src2_idx];

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < `VEC_NUM_REGS; i++) begin
				rf[i]	<= '0;
			end
		end else if (!stall && retire_valid) begin
			rf[retire_idx]	<= retire_data;		// Oldest entry leaves buffer
		end
	end

	lane_bypass_buff u_bypass (
		.clock			(clock),
		.rst			(rst),
		.stall			(stall),
		.wr_valid		(cmd.valid),
		.wr_idx			(cmd.dst),
		.wr_data		(alu_res),
		.rd_idx1		(cmd.src1_idx),
		.rd_idx2		(cmd.src2_idx),
		.rf_data1		(rf_data1),
		.rf_data2		(rf_data2),
		.rd_data1		(opnd1),
		.rd_data2		(opnd2),
		.retire_valid	(retire_valid),
		.retire_idx		(retire_idx),
		.retire_data	(retire_data)
	);

	lane_path_sel u_path_sel (
		.path1			(cmd.src1_path),
		.path2			(cmd.src2_path),
		.own1			(opnd1),
		.own2			(opnd2),
		.left1			(left1),
		.left2			(left2),
		.right1			(right1),
		.right2			(right2),
		.scalar			(cmd.scalar),
		.src1			(alu_a),
		.src2			(alu_b)
	);

	////////////////////
	// ALU

	always_comb begin
		case (cmd.op)
			vec_pkg::OP_ADD:	alu_res = alu_a + alu_b;
			vec_pkg::OP_SUB:	alu_res = alu_a - alu_b;
			vec_pkg::OP_AND:	alu_res = alu_a & alu_b;
			vec_pkg::OP_XOR:	alu_res = alu_a ^ alu_b;
			vec_pkg::OP_BCAST:	alu_res = cmd.scalar;
			vec_pkg::OP_LANEID:	alu_res = vec_pkg::data_t'(LANE_NUM);	// Zero extended
			default:			alu_res = '0;
		endcase
	end

	// Stage B result register
	always_ff @(posedge clock) begin
		if (rst) begin
			res_valid	<= 1'b0;
		end else if (!stall) begin
			res_valid	<= cmd.valid;
		end
	end

	always_ff @(posedge clock) begin
		if (!stall && cmd.valid) begin
			res_dst		<= cmd.dst;
			res_data	<= alu_res;
		end
	end

endmodule

/* vec_lane_array.sv */
/*
 * SIMD vector lane array top
 * Issuer, ring of lanes with neighbour operand paths, write-back collector
 */

`timescale 1ns/1ps

`include "vec_cfg.svh"

module vec_lane_array (
	input							clock,
	input							rst,
	input							stall,
	input							req,
	input	vec_pkg::op_e			op,
	input	vec_pkg::index_t		dst_idx,
	input	vec_pkg::index_t		src1_idx,
	input	vec_pkg::index_t		src2_idx,
	input	vec_pkg::path_e			src1_path,
	input	vec_pkg::path_e			src2_path,
	input	vec_pkg::data_t			scalar_data,
	output	logic					result_valid,
	output	vec_pkg::index_t		result_dst,
	output	logic [`VEC_NUM_LANES*`VEC_DATA_W-1:0]	result_data
);

	localparam int N = `VEC_NUM_LANES;

	lane_cmd_if						cmd_bus ();

	vec_pkg::data_t					opnd1 [N];		// Per-lane bypassed reads
	vec_pkg::data_t					opnd2 [N];
	logic	[N-1:0]					res_valid;
	vec_pkg::index_t				res_dst [N];
	vec_pkg::data_t					res_data [N];

	issue_ctrl u_issue (
		.clock			(clock),
		.rst			(rst),
		.stall			(stall),
		.req			(req),
		.op				(op),
		.dst_idx		(dst_idx),
		.src1_idx		(src1_idx),
		.src2_idx		(src2_idx),
		.src1_path		(src1_path),
		.src2_path		(src2_path),
		.scalar_data	(scalar_data),
		.cmd			(cmd_bus)
	);

	////////////////////
	// Lane ring

	for (genvar i = 0; i < N; i++) begin : g_lane
		vec_lane #(
			.LANE_ID	(i)
		) u_lane (
			.clock		(clock),
			.rst		(rst),
			.stall		(stall),
			.cmd		(cmd_bus),
			.left1		(opnd1[(i + N - 1) % N]),	// Wraps at lane 0
			.left2		(opnd2[(i + N - 1) % N]),
			.right1		(opnd1[(i + 1) % N]),
			.right2		(opnd2[(i + 1) % N]),
			.opnd1		(opnd1[i]),
			.opnd2		(opnd2[i]),
			.res_valid	(res_valid[i]),
			.res_dst	(res_dst[i]),
			.res_data	(res_data[i])
		);
	end

	wb_collector u_collector (
		.clock			(clock),
		.rst			(rst),
		.stall			(stall),
		.lane_valid		(res_valid),
		.lane_dst		(res_dst),
		.lane_data		(res_data),
		.result_valid	(result_valid),
		.result_dst		(result_dst),
		.result_data	(result_data)
	);

endmodule

/* vec_pkg.sv */
/*
 * Vector lane array types
 * Word, index and lane number types, opcode and operand path encodings
 */

`include "vec_cfg.svh"

package vec_pkg;

	typedef logic [`VEC_DATA_W-1:0]				data_t;		// One lane word
	typedef logic [$clog2(`VEC_NUM_REGS)-1:0]	index_t;	// Register index
	typedef logic [$clog2(`VEC_NUM_LANES)-1:0]	lane_id_t;	// Lane number

	// Vector opcodes
	typedef enum logic [2:0] {
		OP_ADD		= 3'd0,
		OP_SUB		= 3'd1,
		OP_AND		= 3'd2,
		OP_XOR		= 3'd3,
		OP_BCAST	= 3'd4,		// Scalar into every lane
		OP_LANEID	= 3'd5		// Own lane number
	} op_e;

	// Operand source of one ALU input
	typedef enum logic [1:0] {
		PATH_OWN	= 2'd0,
		PATH_LEFT	= 2'd1,		// Lane i-1
		PATH_RIGHT	= 2'd2,		// Lane i+1
		PATH_SCALAR	= 2'd3
	} path_e;

endpackage

/* wb_collector.sv */
/*
 * Write-back collector
 * Registers all lane results into one packed result vector
 */

`timescale 1ns/1ps

`include "vec_cfg.svh"

module wb_collector (
	input							clock,
	input							rst,
	input							stall,
	input	[`VEC_NUM_LANES-1:0]	lane_valid,
	input	vec_pkg::index_t		lane_dst [`VEC_NUM_LANES],
	input	vec_pkg::data_t			lane_data [`VEC_NUM_LANES],
	output	logic					result_valid,
	output	vec_pkg::index_t		result_dst,
	output	logic [`VEC_NUM_LANES*`VEC_DATA_W-1:0]	result_data	// Lane 0 in low word
);

	always_ff @(posedge clock) begin
		if (rst) begin
			result_valid	<= 1'b0;
		end else if (!stall) begin
			result_valid	<= lane_valid[0];
		end
	end

	always_ff @(posedge clock) begin
		if (!stall && lane_valid[0]) begin
			result_dst		<= lane_dst[0];		// Lanes run in lockstep
			for (int i = 0; i < `VEC_NUM_LANES; i++) begin
				result_data[i*`VEC_DATA_W +: `VEC_DATA_W]	<= lane_data[i];
			end
		end
	end

endmodule
